/* src/vp_pkg.sv */
package vp_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Bus words
	////////////////////////////////////////////////////////////////////////////

	// Console colour bits, packed order gives the LUT index
	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic luma;
	} vp_pixel_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} vp_rgb_t;

	// Host download strobe
	typedef struct packed {
		logic        download;
		logic        wr;
		logic [7:0]  index;
		logic [13:0] addr;
	} vp_load_t;

	// Cartridge side of the console
	typedef struct packed {
		logic [11:0] addr;
		logic        bank0;
		logic        bank1;
	} vp_cart_bus_t;

	// PS/2 key word, toggle flips once per key edge
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} vp_ps2_t;

	typedef struct packed {
		logic [7:0] ascii;
		logic       released;
	} vp_key_event_t;

	////////////////////////////////////////////////////////////////////////////
	// Constants
	////////////////////////////////////////////////////////////////////////////

	localparam int ROM_AW   = 14;
	localparam int NUMPAD_W = 10;

	// Enable periods in clk_sys cycles
	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int VDC_DIV_NTSC = 6;
	localparam int VDC_DIV_PAL  = 10;

	// Download index of an XROM image
	localparam int XROM_INDEX = 2;

	// Image sizes in bytes
	localparam int CART_4K  = 4096;
	localparam int CART_8K  = 8192;
	localparam int CART_16K = 16384;

	// Set-2 scancode to ASCII, extended prefix not looked at
	function automatic logic [7:0] ps2_to_ascii(input logic [7:0] code);
		case (code)
			// Digit row
			8'h16: return "1";
			8'h1E: return "2";
			8'h26: return "3";
			8'h25: return "4";
			8'h2E: return "5";
			8'h36: return "6";
			8'h3D: return "7";
			8'h3E: return "8";
			8'h46: return "9";
			8'h45: return "0";
			// Letters
			8'h1C: return "a";
			8'h32: return "b";
			8'h21: return "c";
			8'h23: return "d";
			8'h24: return "e";
			8'h2B: return "f";
			8'h34: return "g";
			8'h33: return "h";
			8'h43: return "i";
			8'h3B: return "j";
			8'h42: return "k";
			8'h4B: return "l";
			8'h3A: return "m";
			8'h31: return "n";
			8'h44: return "o";
			8'h4D: return "p";
			8'h15: return "q";
			8'h2D: return "r";
			8'h1B: return "s";
			8'h2C: return "t";
			8'h3C: return "u";
			8'h2A: return "v";
			8'h1D: return "w";
			8'h22: return "x";
			8'h35: return "y";
			8'h1A: return "z";
			// Punctuation, keypad operators
			8'h29: return " ";
			8'h79: return "+";
			8'h7B: return "-";
			8'h7C: return "*";
			8'h4A: return "/";
			8'h55: return "=";
			// GUI keys act as yes and no
			8'h1F: return 8'h11;
			8'h27: return 8'h12;
			// Enter and backspace
			8'h5A: return 8'h0A;
			8'h66: return 8'h08;
			default: return 8'h00;
		endcase
	endfunction

endpackage

/* src/vp_clock_enables.sv */
`timescale 1ns/1ns

module vp_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	input  logic std_pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);
	import vp_pkg::*;

	// Channel 0 is the CPU enable, channel 1 the VDC enable
	localparam int N_EN = 2;

	// Reload is period minus one, count runs down to zero
	localparam logic [3:0] RELOAD_NTSC [N_EN] = '{4'(CPU_DIV_NTSC - 1), 4'(VDC_DIV_NTSC - 1)};
	localparam logic [3:0] RELOAD_PAL  [N_EN] = '{4'(CPU_DIV_PAL - 1), 4'(VDC_DIV_PAL - 1)};

	logic            std_q;
	logic            restart;
	logic [3:0]      cnt_q [N_EN];
	logic [N_EN-1:0] en_q;

	// Standard seen last cycle
	always_ff @(posedge clk_sys) begin
		std_q <= std_pal_i;
	end

	// Any change of standard starts both dividers over
	assign restart = (std_pal_i != std_q);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			en_q <= '0;
			for (int i = 0; i < N_EN; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < N_EN; i++) begin
				if (restart) begin
					cnt_q[i] <= '0;
					en_q[i] <= 1'b0;
				end else begin
					// Pulse on the step from 1 to 0
					en_q[i] <= (cnt_q[i] == 4'd1);
					if (cnt_q[i] == '0) begin
						cnt_q[i] <= std_q ? RELOAD_PAL[i] : RELOAD_NTSC[i];
					end else begin
						cnt_q[i] <= cnt_q[i] - 4'd1;
					end
				end
			end
		end
	end

	assign cpu_en_o = en_q[0];
	assign vdc_en_o = en_q[1];

endmodule

/* src/vp_cart_mapper.sv */
`timescale 1ns/1ns

module vp_cart_mapper #(
	parameter int ROM_AW = vp_pkg::ROM_AW
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  vp_pkg::vp_load_t     load_i,
	input  vp_pkg::vp_cart_bus_t cart_i,
	output logic [ROM_AW-1:0]    rom_addr_o,
	output logic                 rom_we_o
);
	import vp_pkg::*;

	logic              dl_q;
	logic              xrom_q;
	logic [15:0]       size_q;
	logic              host_sel;
	logic [10:0]       page_addr;
	logic [ROM_AW-1:0] cart_addr;

	////////////////////////////////////////////////////////////////////////////
	// Download tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_q   <= 1'b0;
			xrom_q <= 1'b0;
			size_q <= '0;
		end else begin
			dl_q <= load_i.download;
			// New image, start counting from zero
			if (load_i.download && !dl_q) begin
				size_q <= '0;
				xrom_q <= (load_i.index == 8'(XROM_INDEX));
			end else if (load_i.download && load_i.wr) begin
				size_q <= size_q + 16'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address mapping
	////////////////////////////////////////////////////////////////////////////

	// Indices 0 to 2 are cartridge images, 3 and up go elsewhere
	assign host_sel = load_i.download && (load_i.index < 8'd3);

	// A10 is skipped on banked images
	assign page_addr = {cart_i.addr[11], cart_i.addr[9:0]};

	always_comb begin
		if (xrom_q) begin
			// XROM sees the flat 4K window
			cart_addr = ROM_AW'(cart_i.addr);
		end else begin
			case (size_q)
				16'(CART_4K):  cart_addr = ROM_AW'({1'b0, cart_i.bank0, page_addr});
				16'(CART_8K):  cart_addr = ROM_AW'({cart_i.bank1, cart_i.bank0, page_addr});
				// 12K in a 16K slot, full A11..A0 per bank
				16'(CART_16K): cart_addr = ROM_AW'({cart_i.bank1, cart_i.bank0, cart_i.addr});
				default:       cart_addr = ROM_AW'({2'b00, page_addr});
			endcase
		end
	end

	// Host owns the ROM port while loading a cart
	assign rom_addr_o = host_sel ? ROM_AW'(load_i.addr) : cart_addr;
	assign rom_we_o   = host_sel & load_i.wr;

endmodule

/* src/vp_palette.sv */
`timescale 1ns/1ns

module vp_palette #(
	parameter int GRAY_R = 77,
	parameter int GRAY_G = 150,
	parameter int GRAY_B = 29
) (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              std_pal_i,
	input  logic              mono_i,
	input  vp_pkg::vp_pixel_t pixel_i,
	input  logic              pix_valid_i,
	output vp_pkg::vp_rgb_t   rgb_o,
	output logic              rgb_valid_o
);
	import vp_pkg::*;

	////////////////////////////////////////////////////////////////////////////
	// Calibrated tables, index is {r, g, b, luma}
	////////////////////////////////////////////////////////////////////////////

	localparam logic [23:0] NTSC_LUT [16] = '{
		24'h000000,
		24'h676767,
		24'h1A37BE,
		24'h5C80F6,
		24'h006D07,
		24'h56C469,
		24'h2AAABE,
		24'h77E6EB,
		24'h790000,
		24'hC75151,
		24'h94309F,
		24'hDC84E8,
		24'h77670B,
		24'hC6B86A,
		24'hCECECE,
		24'hFFFFFF
	};

	// PAL set is flatter, bright entries saturate
	localparam logic [23:0] PAL_LUT [16] = '{
		24'h000000,
		24'h494949,
		24'h0000B6,
		24'h4949FF,
		24'h00B601,
		24'h49FF49,
		24'h00B6C9,
		24'h49FFFF,
		24'hB60000,
		24'hFF4949,
		24'hB600B6,
		24'hFF49FF,
		24'hB6B600,
		24'hFFFF49,
		24'hB6B6B6,
		24'hFFFFFF
	};

	logic [3:0]  lut_idx;
	vp_rgb_t     ntsc_rgb;
	vp_rgb_t     pal_rgb;
	logic [15:0] gray_sum;
	logic [7:0]  gray;
	vp_rgb_t     rgb_d;
	vp_rgb_t     rgb_q;
	logic        valid_q;

	assign lut_idx  = pixel_i;
	assign ntsc_rgb = NTSC_LUT[lut_idx];
	assign pal_rgb  = PAL_LUT[lut_idx];

	// Weighted luminance, weights sum to 256
	assign gray_sum = 16'(GRAY_R * pal_rgb.r + GRAY_G * pal_rgb.g + GRAY_B * pal_rgb.b);
	assign gray     = gray_sum[15:8];

	always_comb begin
		if (mono_i) begin
			// G7200 style, one level on all guns
			rgb_d.r = gray;
			rgb_d.g = gray;
			rgb_d.b = gray;
		end else if (std_pal_i) begin
			rgb_d = pal_rgb;
		end else begin
			rgb_d = ntsc_rgb;
		end
	end

	// Pixel stage
	always_ff @(posedge clk_sys) begin
		rgb_q <= rgb_d;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= pix_valid_i;
		end
	end

	assign rgb_o       = rgb_q;
	assign rgb_valid_o = valid_q;

endmodule

/* src/vp_key_encoder.sv */
`timescale 1ns/1ns

module vp_key_encoder (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  vp_pkg::vp_ps2_t             ps2_i,
	input  logic [vp_pkg::NUMPAD_W-1:0] numpad_i,
	input  logic                        key_ack_i,
	output vp_pkg::vp_key_event_t       key_o,
	output logic                        key_req_o
);
	import vp_pkg::*;

	// Handshake states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT_REL
	} state_t;

	state_t              state_q;
	logic                toggle_q;
	logic [NUMPAD_W-1:0] numpad_q;
	logic [7:0]          last_digit_q;
	logic                ps2_evt;
	logic                pad_evt;
	logic                any_evt;
	logic [7:0]          pad_digit;
	vp_key_event_t       evt_d;
	vp_key_event_t       key_q;

	////////////////////////////////////////////////////////////////////////////
	// Event detection
	////////////////////////////////////////////////////////////////////////////

	// Input history for edge detection
	always_ff @(posedge clk_sys) begin
		toggle_q <= ps2_i.toggle;
		numpad_q <= numpad_i;
	end

	assign ps2_evt = (ps2_i.toggle != toggle_q);
	assign pad_evt = (numpad_i != numpad_q);
	assign any_evt = ps2_evt | pad_evt;

	// Lowest set button wins, top bit is the 0 key
	always_comb begin
		pad_digit = 8'h00;
		for (int i = NUMPAD_W - 1; i >= 0; i--) begin
			if (numpad_i[i]) begin
				pad_digit = (i == NUMPAD_W - 1) ? "0" : 8'("1" + i);
			end
		end
	end

	// PS/2 has priority over the pad
	always_comb begin
		if (ps2_evt) begin
			evt_d.ascii    = ps2_to_ascii(ps2_i.code);
			evt_d.released = ~ps2_i.pressed;
		end else if (|numpad_i) begin
			evt_d.ascii    = pad_digit;
			evt_d.released = 1'b0;
		end else begin
			// All buttons up, release what was held
			evt_d.ascii    = last_digit_q;
			evt_d.released = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state_q      <= ST_IDLE;
			last_digit_q <= 8'h00;
		end else begin
			if (pad_evt && |numpad_i) begin
				last_digit_q <= pad_digit;
			end
			case (state_q)
				// Events seen outside idle are lost
				ST_IDLE: begin
					if (any_evt) begin
						state_q <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (key_ack_i) begin
						state_q <= ST_WAIT_REL;
					end
				end
				// Ack must drop before the next request
				ST_WAIT_REL: begin
					if (!key_ack_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// Held stable for the whole transfer
	always_ff @(posedge clk_sys) begin
		if (state_q == ST_IDLE && any_evt) begin
			key_q <= evt_d;
		end
	end

	assign key_o     = key_q;
	assign key_req_o = (state_q == ST_REQ);

endmodule

/* src/vp_glue_top.sv */
`timescale 1ns/1ns

module vp_glue_top #(
	parameter int GRAY_R = 77,
	parameter int GRAY_G = 150,
	parameter int GRAY_B = 29
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        std_pal_i,
	input  logic                        mono_i,
	input  vp_pkg::vp_load_t            load_i,
	input  vp_pkg::vp_cart_bus_t        cart_i,
	input  vp_pkg::vp_pixel_t           pixel_i,
	input  logic                        pix_valid_i,
	input  vp_pkg::vp_ps2_t             ps2_i,
	input  logic [vp_pkg::NUMPAD_W-1:0] numpad_i,
	input  logic                        key_ack_i,
	output logic                        cpu_en_o,
	output logic                        vdc_en_o,
	output logic [vp_pkg::ROM_AW-1:0]   rom_addr_o,
	output logic                        rom_we_o,
	output vp_pkg::vp_rgb_t             rgb_o,
	output logic                        rgb_valid_o,
	output vp_pkg::vp_key_event_t       key_o,
	output logic                        key_req_o
);
	import vp_pkg::*;

	// CPU and VDC enables
	vp_clock_enables u_clock_enables (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.std_pal_i (std_pal_i),
		.cpu_en_o  (cpu_en_o),
		.vdc_en_o  (vdc_en_o)
	);

	// Cartridge ROM port
	vp_cart_mapper #(
		.ROM_AW (ROM_AW)
	) u_cart_mapper (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_i     (load_i),
		.cart_i     (cart_i),
		.rom_addr_o (rom_addr_o),
		.rom_we_o   (rom_we_o)
	);

	// Colour out, gray weights from here
	vp_palette #(
		.GRAY_R (GRAY_R),
		.GRAY_G (GRAY_G),
		.GRAY_B (GRAY_B)
	) u_palette (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.std_pal_i   (std_pal_i),
		.mono_i      (mono_i),
		.pixel_i     (pixel_i),
		.pix_valid_i (pix_valid_i),
		.rgb_o       (rgb_o),
		.rgb_valid_o (rgb_valid_o)
	);

	// Keyboard and numpad to key events
	vp_key_encoder u_key_encoder (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_i     (ps2_i),
		.numpad_i  (numpad_i),
		.key_ack_i (key_ack_i),
		.key_o     (key_o),
		.key_req_o (key_req_o)
	);

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk_sys
);

	// Free running system clock
	initial begin
		clk_sys = 1'b0;
	end

	always #(PERIOD / 2) clk_sys = ~clk_sys;

endmodule

/* test/tb_checker.sv */
`timescale 1ns/1ns

module tb_checker (
	input logic                        clk_sys,
	input logic                        reset,
	input logic                        std_pal_i,
	input logic                        mono_i,
	input vp_pkg::vp_load_t            load_i,
	input vp_pkg::vp_cart_bus_t        cart_i,
	input vp_pkg::vp_pixel_t           pixel_i,
	input logic                        pix_valid_i,
	input vp_pkg::vp_ps2_t             ps2_i,
	input logic [vp_pkg::NUMPAD_W-1:0] numpad_i,
	input logic                        key_ack_i,
	input logic                        cpu_en_o,
	input logic                        vdc_en_o,
	input logic [vp_pkg::ROM_AW-1:0]   rom_addr_o,
	input logic                        rom_we_o,
	input vp_pkg::vp_rgb_t             rgb_o,
	input logic                        rgb_valid_o,
	input vp_pkg::vp_key_event_t       key_o,
	input logic                        key_req_o,
	output int                         clk_errs_o,
	output int                         cart_errs_o,
	output int                         pal_errs_o,
	output int                         key_errs_o,
	output int                         pending_o
);
	import vp_pkg::*;

	localparam int GRAY_R = 77;
	localparam int GRAY_G = 150;
	localparam int GRAY_B = 29;

	localparam logic [23:0] NTSC_COLORS [16] = '{
		24'h000000, 24'h676767, 24'h1A37BE, 24'h5C80F6,
		24'h006D07, 24'h56C469, 24'h2AAABE, 24'h77E6EB,
		24'h790000, 24'hC75151, 24'h94309F, 24'hDC84E8,
		24'h77670B, 24'hC6B86A, 24'hCECECE, 24'hFFFFFF
	};
	localparam logic [23:0] PAL_COLORS [16] = '{
		24'h000000, 24'h494949, 24'h0000B6, 24'h4949FF,
		24'h00B601, 24'h49FF49, 24'h00B6C9, 24'h49FFFF,
		24'hB60000, 24'hFF4949, 24'hB600B6, 24'hFF49FF,
		24'hB6B600, 24'hFFFF49, 24'hB6B6B6, 24'hFFFFFF
	};

	// Set-2 codes and their characters in matching order
	localparam logic [7:0] SCAN_CODES [46] = '{
		8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46, 8'h45,
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
		8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
		8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A,
		8'h29, 8'h79, 8'h7B, 8'h7C, 8'h4A, 8'h55, 8'h1F, 8'h27, 8'h5A, 8'h66
	};
	localparam logic [7:0] SCAN_CHARS [46] = '{
		8'h31, 8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37, 8'h38, 8'h39, 8'h30,
		8'h61, 8'h62, 8'h63, 8'h64, 8'h65, 8'h66, 8'h67, 8'h68, 8'h69, 8'h6A,
		8'h6B, 8'h6C, 8'h6D, 8'h6E, 8'h6F, 8'h70, 8'h71, 8'h72, 8'h73, 8'h74,
		8'h75, 8'h76, 8'h77, 8'h78, 8'h79, 8'h7A,
		8'h20, 8'h2B, 8'h2D, 8'h2A, 8'h2F, 8'h3D, 8'h11, 8'h12, 8'h0A, 8'h08
	};

	int          clk_errs = 0;
	int          cart_errs = 0;
	int          pal_errs = 0;
	int          key_errs = 0;
	int          cyc = 0;
	int          last_pulse [2];
	bit          have_prev [2];
	logic        std_prev;
	logic        dl_prev;
	logic        xrom_m;
	int          size_m;
	logic [23:0] rgb_exp;
	logic        valid_exp;
	logic        toggle_prev;
	logic [9:0]  pad_prev;
	logic [7:0]  last_digit_m;
	logic [8:0]  key_exp_q [$];
	logic [8:0]  key_held;
	logic        req_prev;
	logic        ack_prev;
	logic        ack_low_seen;

	assign clk_errs_o  = clk_errs;
	assign cart_errs_o = cart_errs;
	assign pal_errs_o  = pal_errs;
	assign key_errs_o  = key_errs;

	task automatic show_mismatch(
		input string       name,
		input logic [31:0] exp,
		input logic [31:0] act
	);
		$display("Fail %s: expected %h, actual %h", name, exp, act);
	endtask

	function automatic logic [7:0] ascii_of_code(input logic [7:0] code);
		logic [7:0] a;
		a = 8'h00;
		for (int i = 0; i < 46; i++) begin
			if (SCAN_CODES[i] == code) begin
				a = SCAN_CHARS[i];
			end
		end
		return a;
	endfunction

	function automatic logic [13:0] mapped_rom_addr(input vp_cart_bus_t c);
		if (xrom_m) begin
			return {2'b00, c.addr};
		end
		case (size_m)
			CART_4K:  return 14'({1'b0, c.bank0, c.addr[11], c.addr[9:0]});
			CART_8K:  return 14'({c.bank1, c.bank0, c.addr[11], c.addr[9:0]});
			CART_16K: return {c.bank1, c.bank0, c.addr};
			default:  return 14'({2'b00, c.addr[11], c.addr[9:0]});
		endcase
	endfunction

	function automatic logic [7:0] gray_of(input logic [23:0] c);
		int s;
		s = GRAY_R * int'(c[23:16]) + GRAY_G * int'(c[15:8]) + GRAY_B * int'(c[7:0]);
		return 8'(s >> 8);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Per block checks at each rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic time_enables();
		logic en;
		int   div;
		for (int i = 0; i < 2; i++) begin
			en  = (i == 0) ? cpu_en_o : vdc_en_o;
			// Period of the standard that ran up to this edge
			if (i == 0) begin
				div = std_prev ? CPU_DIV_PAL : CPU_DIV_NTSC;
			end else begin
				div = std_prev ? VDC_DIV_PAL : VDC_DIV_NTSC;
			end
			if (en) begin
				if (have_prev[i] && cyc - last_pulse[i] != div) begin
					show_mismatch(i == 0 ? "cpu_en period" : "vdc_en period",
						div, cyc - last_pulse[i]);
					clk_errs++;
				end
				last_pulse[i] = cyc;
				have_prev[i]  = 1'b1;
			end else if (have_prev[i] && cyc - last_pulse[i] > div) begin
				$display("Enable %0d gave no pulse within its period", i);
				clk_errs++;
				last_pulse[i] = cyc;
			end
		end
		// Both dividers are zero from this edge on
		if (std_pal_i != std_prev) begin
			for (int i = 0; i < 2; i++) begin
				last_pulse[i] = cyc + 1;
				have_prev[i]  = 1'b1;
			end
		end
		std_prev = std_pal_i;
	endtask

	task automatic compare_rom_port();
		logic [13:0] exp_addr;
		logic        exp_we;
		if (load_i.download && load_i.index < 8'd3) begin
			exp_addr = load_i.addr;
			exp_we   = load_i.wr;
		end else begin
			exp_addr = mapped_rom_addr(cart_i);
			exp_we   = 1'b0;
		end
		if (rom_addr_o !== exp_addr) begin
			show_mismatch("rom_addr", 32'(exp_addr), 32'(rom_addr_o));
			cart_errs++;
		end
		if (rom_we_o !== exp_we) begin
			show_mismatch("rom_we", 32'(exp_we), 32'(rom_we_o));
			cart_errs++;
		end
		// Size and type as of the next edge
		if (load_i.download && !dl_prev) begin
			size_m = 0;
			xrom_m = (load_i.index == 8'(XROM_INDEX));
		end else if (load_i.download && load_i.wr) begin
			size_m++;
		end
		dl_prev = load_i.download;
	endtask

	task automatic score_palette();
		logic [23:0] pal_c;
		logic [7:0]  g;
		if (rgb_valid_o !== valid_exp) begin
			show_mismatch("rgb_valid", 32'(valid_exp), 32'(rgb_valid_o));
			pal_errs++;
		end
		if (valid_exp && rgb_o !== rgb_exp) begin
			show_mismatch("rgb", 32'(rgb_exp), 32'(rgb_o));
			pal_errs++;
		end
		pal_c = PAL_COLORS[pixel_i];
		g     = gray_of(pal_c);
		valid_exp = pix_valid_i;
		if (mono_i) begin
			rgb_exp = {g, g, g};
		end else begin
			rgb_exp = std_pal_i ? pal_c : NTSC_COLORS[pixel_i];
		end
	endtask

	task automatic follow_keys();
		logic [8:0] exp;
		logic [7:0] d;
		bit         found;
		if (key_req_o && !req_prev) begin
			if (!ack_low_seen) begin
				$display("Key request rose before acknowledge was seen low");
				key_errs++;
			end
			ack_low_seen = 1'b0;
			if (key_exp_q.size() == 0) begin
				$display("Key request raised with no input event behind it");
				key_errs++;
			end else begin
				exp = key_exp_q.pop_front();
				if (key_o !== exp) begin
					show_mismatch("key event", 32'(exp), 32'(key_o));
					key_errs++;
				end
			end
			key_held = key_o;
		end else if (key_req_o && key_o !== key_held) begin
			$display("Key event changed while the request was high");
			key_errs++;
		end
		if (req_prev && ack_prev && key_req_o) begin
			$display("Key request stayed high after acknowledge");
			key_errs++;
		end
		if (!key_ack_i && !key_req_o) begin
			ack_low_seen = 1'b1;
		end
		// Expected events from input changes
		if (ps2_i.toggle != toggle_prev) begin
			key_exp_q.push_back({ascii_of_code(ps2_i.code), ~ps2_i.pressed});
		end else if (numpad_i != pad_prev) begin
			if (numpad_i != '0) begin
				found = 1'b0;
				d     = 8'h00;
				for (int i = 0; i < NUMPAD_W; i++) begin
					if (numpad_i[i] && !found) begin
						found = 1'b1;
						d     = (i == NUMPAD_W - 1) ? 8'h30 : 8'(8'h31 + i);
					end
				end
				key_exp_q.push_back({d, 1'b0});
				last_digit_m = d;
			end else begin
				key_exp_q.push_back({last_digit_m, 1'b1});
			end
		end
		toggle_prev = ps2_i.toggle;
		pad_prev    = numpad_i;
		req_prev    = key_req_o;
		ack_prev    = key_ack_i;
	endtask

	always @(posedge clk_sys) begin
		cyc++;
		if (reset) begin
			// Counters sit at zero when reset lets go
			for (int i = 0; i < 2; i++) begin
				last_pulse[i] = cyc + 1;
				have_prev[i]  = 1'b1;
			end
			std_prev     = std_pal_i;
			dl_prev      = 1'b0;
			xrom_m       = 1'b0;
			size_m       = 0;
			valid_exp    = 1'b0;
			toggle_prev  = ps2_i.toggle;
			pad_prev     = numpad_i;
			last_digit_m = 8'h00;
			req_prev     = 1'b0;
			ack_prev     = 1'b0;
			ack_low_seen = 1'b1;
			key_exp_q.delete();
		end else begin
			time_enables();
			compare_rom_port();
			score_palette();
			follow_keys();
		end
		pending_o = key_exp_q.size();
	end

endmodule

/* test/tb_top.sv */
`timescale 1ns/1ns

module tb_top;
	import vp_pkg::*;

	localparam int RESET_CYCLES = 5;
	localparam int ENABLE_LEN   = 400;
	localparam int MAP_LEN      = 64;
	localparam int DL_LEN       = 4096 + 8192 + 16384 + 300 + 100 + 1000 + 6 * (MAP_LEN + 2);
	localparam int PAL_LEN      = 500;
	localparam int PS2_EVENTS   = 60;
	localparam int PAD_EVENTS   = 40;
	// Worst case handshake with both random delays
	localparam int EVENT_MAX    = 20;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + ENABLE_LEN + DL_LEN + PAL_LEN
	                              + (PS2_EVENTS + PAD_EVENTS) * EVENT_MAX + 1000;

	logic                clk_sys;
	logic                reset;
	logic                std_pal_i;
	logic                mono_i;
	vp_load_t            load_i;
	vp_cart_bus_t        cart_i;
	vp_pixel_t           pixel_i;
	logic                pix_valid_i;
	vp_ps2_t             ps2_i;
	logic [NUMPAD_W-1:0] numpad_i;
	logic                key_ack_i;
	logic                cpu_en_o;
	logic                vdc_en_o;
	logic [ROM_AW-1:0]   rom_addr_o;
	logic                rom_we_o;
	vp_rgb_t             rgb_o;
	logic                rgb_valid_o;
	vp_key_event_t       key_o;
	logic                key_req_o;
	int                  clk_errs;
	int                  cart_errs;
	int                  pal_errs;
	int                  key_errs;
	int                  pending;
	int                  misc_errs;
	int                  cycle_cnt;
	logic [31:0]         rng_state;

	tb_clock #(.PERIOD(40)) u_clock (.clk_sys(clk_sys));

	vp_glue_top #(
		.GRAY_R (77),
		.GRAY_G (150),
		.GRAY_B (29)
	) DUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.std_pal_i   (std_pal_i),
		.mono_i      (mono_i),
		.load_i      (load_i),
		.cart_i      (cart_i),
		.pixel_i     (pixel_i),
		.pix_valid_i (pix_valid_i),
		.ps2_i       (ps2_i),
		.numpad_i    (numpad_i),
		.key_ack_i   (key_ack_i),
		.cpu_en_o    (cpu_en_o),
		.vdc_en_o    (vdc_en_o),
		.rom_addr_o  (rom_addr_o),
		.rom_we_o    (rom_we_o),
		.rgb_o       (rgb_o),
		.rgb_valid_o (rgb_valid_o),
		.key_o       (key_o),
		.key_req_o   (key_req_o)
	);

	tb_checker u_checker (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.std_pal_i   (std_pal_i),
		.mono_i      (mono_i),
		.load_i      (load_i),
		.cart_i      (cart_i),
		.pixel_i     (pixel_i),
		.pix_valid_i (pix_valid_i),
		.ps2_i       (ps2_i),
		.numpad_i    (numpad_i),
		.key_ack_i   (key_ack_i),
		.cpu_en_o    (cpu_en_o),
		.vdc_en_o    (vdc_en_o),
		.rom_addr_o  (rom_addr_o),
		.rom_we_o    (rom_we_o),
		.rgb_o       (rgb_o),
		.rgb_valid_o (rgb_valid_o),
		.key_o       (key_o),
		.key_req_o   (key_req_o),
		.clk_errs_o  (clk_errs),
		.cart_errs_o (cart_errs),
		.pal_errs_o  (pal_errs),
		.key_errs_o  (key_errs),
		.pending_o   (pending)
	);

	// xorshift32 step
	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus phases
	////////////////////////////////////////////////////////////////////////////

	task automatic switch_standards();
		repeat (ENABLE_LEN) begin
			@(negedge clk_sys);
			// Rare switch of standard
			if (next_rand() % 64 == 0) begin
				std_pal_i = ~std_pal_i;
			end
		end
	endtask

	task automatic load_image(input logic [7:0] index, input int len);
		@(negedge clk_sys);
		load_i.download = 1'b1;
		load_i.index    = index;
		load_i.wr       = 1'b0;
		repeat (len) begin
			@(negedge clk_sys);
			load_i.wr   = 1'b1;
			load_i.addr = 14'(next_rand() >> 18);
			cart_i      = vp_cart_bus_t'(14'(next_rand() >> 18));
		end
		@(negedge clk_sys);
		load_i = '0;
		// Console side reads with the new mapping
		repeat (MAP_LEN) begin
			@(negedge clk_sys);
			cart_i = vp_cart_bus_t'(14'(next_rand() >> 18));
		end
	endtask

	task automatic drive_pixels();
		logic [31:0] r;
		repeat (PAL_LEN) begin
			@(negedge clk_sys);
			r           = next_rand();
			pixel_i     = vp_pixel_t'(r[3:0]);
			pix_valid_i = r[4];
			mono_i      = r[5];
			std_pal_i   = r[6];
		end
		@(negedge clk_sys);
		pix_valid_i = 1'b0;
	endtask

	// Consumer side answers after random delays
	task automatic complete_handshake();
		while (!key_req_o) begin
			@(negedge clk_sys);
		end
		repeat (next_rand() % 6) @(negedge clk_sys);
		key_ack_i = 1'b1;
		@(negedge clk_sys);
		while (key_req_o) begin
			@(negedge clk_sys);
		end
		repeat (next_rand() % 6) @(negedge clk_sys);
		key_ack_i = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic type_scancodes();
		logic [31:0] r;
		repeat (PS2_EVENTS) begin
			@(negedge clk_sys);
			r              = next_rand();
			ps2_i.toggle   = ~ps2_i.toggle;
			ps2_i.pressed  = r[8];
			ps2_i.extended = r[9];
			ps2_i.code     = r[7:0];
			complete_handshake();
		end
	endtask

	task automatic press_numpad();
		logic [31:0]         r;
		logic [NUMPAD_W-1:0] w;
		repeat (PAD_EVENTS) begin
			@(negedge clk_sys);
			r = next_rand();
			w = r[NUMPAD_W-1:0];
			if (r[31:30] == 2'b00) begin
				w = '0;
			end
			// Word must change to make an event
			if (w == numpad_i) begin
				w = w ^ 10'h001;
			end
			numpad_i = w;
			complete_handshake();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Sequence and end of run
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rng_state   = 32'd48431;
		misc_errs   = 0;
		reset       = 1'b1;
		std_pal_i   = 1'b0;
		mono_i      = 1'b0;
		load_i      = '0;
		cart_i      = '0;
		pixel_i     = '0;
		pix_valid_i = 1'b0;
		ps2_i       = '0;
		numpad_i    = '0;
		key_ack_i   = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk_sys);
		reset = 1'b0;

		switch_standards();
		load_image(8'd0, CART_4K);
		load_image(8'd1, CART_8K);
		load_image(8'd0, CART_16K);
		load_image(8'(XROM_INDEX), 50 + int'(next_rand() % 250));
		load_image(8'd5, 100);
		load_image(8'd0, 1 + int'(next_rand() % 1000));
		drive_pixels();
		type_scancodes();
		press_numpad();
		repeat (5) @(negedge clk_sys);

		if (pending != 0) begin
			$display("Key events expected but never requested: %0d", pending);
			misc_errs++;
		end
		$display("Errors: enables %0d, cart %0d, palette %0d, keys %0d, other %0d",
			clk_errs, cart_errs, pal_errs, key_errs, misc_errs);
		if (clk_errs + cart_errs + pal_errs + key_errs + misc_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// Hang guard
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
		$display("TEST FAIL");
		$finish;
	end

endmodule

/* list.f */
src/vp_pkg.sv
src/vp_clock_enables.sv
src/vp_cart_mapper.sv
src/vp_palette.sv
src/vp_key_encoder.sv
src/vp_glue_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

/* run.sh */
#!/bin/bash
# Build with Verilator and run; the log decides pass or fail
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_top -Mdir obj_dir -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete" >> sim.log
cat sim.log
grep -qx "TEST PASS" sim.log && exit 0 || exit 1
